// File: build.f
+incdir+hdl
hdl/regfile_pkg.sv
hdl/int_reg_bank.sv
hdl/fp_reg_bank.sv
hdl/operand_read.sv
hdl/reg_file.sv
verif/reg_file_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the register file testbench with Verilator.
set -e

cd "$(dirname "$0")"

log_file=sim.log

rm -rf obj_dir

verilator --binary --timing --assert \
        -f build.f \
        --top-module reg_file_tb \
        -o Vreg_file_tb

sim_status=0
./obj_dir/Vreg_file_tb > "$log_file" 2>&1 || sim_status=$?

cat "$log_file"

if [ "$sim_status" -eq 0 ] && grep -qx "Everything OK" "$log_file"; then
        echo "simulation passed"
        exit 0
else
        echo "simulation failed (exit status $sim_status)"
        exit 1
fi

// File: verif/reg_file_tb.sv
`timescale 1ns/100ps
`include "regfile_macros.svh"

module reg_file_tb;

        localparam int cycle_limit = 600; // stimulus needs roughly 450

        logic                    clk_i = 1'b0;
        logic                    reset_i;
        regfile_pkg::reg_write_t wr;
        regfile_pkg::reg_id_t    rs1_id;
        regfile_pkg::reg_id_t    rs2_id;
        regfile_pkg::reg_id_t    rs3_id;
        regfile_pkg::flen_word_t rs1_data;
        regfile_pkg::flen_word_t rs2_data;
        regfile_pkg::flen_word_t rs3_data;

        // shadow copy of both banks
        regfile_pkg::xlen_word_t int_model [`REG_COUNT];
        regfile_pkg::flen_word_t fp_model [`REG_COUNT];
        regfile_pkg::flen_word_t rs1_exp;
        regfile_pkg::flen_word_t rs2_exp;
        regfile_pkg::flen_word_t rs3_exp;

        int error_count = 0;
        int cycle_count = 0;

        reg_file reg_file_i (
                .clk_i      (clk_i),
                .reset_i    (reset_i),
                .wr_i       (wr),
                .rs1_i      (rs1_id),
                .rs2_i      (rs2_id),
                .rs3_i      (rs3_id),
                .rs1_data_o (rs1_data),
                .rs2_data_o (rs2_data),
                .rs3_data_o (rs3_data)
        );

        always #5 clk_i = ~clk_i;

        always @(posedge clk_i) begin
                if (reset_i) begin
                        for (int i = 0; i < `REG_COUNT; i++) begin
                                int_model[i] <= '0;
                                fp_model[i]  <= '0;
                        end
                end else if (wr.rd.is_fp) begin
                        fp_model[wr.rd.idx] <= wr.data;
                end else if (wr.rd.idx != '0) begin
                        int_model[wr.rd.idx] <= wr.data[`XLEN-1:0]; // x0 writes dropped
                end
        end

        // integer reads come back as ones over the 32-bit value
        always_comb begin
                rs1_exp = rs1_id.is_fp ? fp_model[rs1_id.idx] :
                          {{`XLEN{1'b1}}, int_model[rs1_id.idx]};
                rs2_exp = rs2_id.is_fp ? fp_model[rs2_id.idx] :
                          {{`XLEN{1'b1}}, int_model[rs2_id.idx]};
                rs3_exp = rs3_id.is_fp ? fp_model[rs3_id.idx] :
                          {{`XLEN{1'b1}}, int_model[rs3_id.idx]};
        end

        a_rs1_matches: assert property (@(posedge clk_i) disable iff (reset_i)
                rs1_data == rs1_exp)
                else begin
                        error_count++;
                        $display("** Error at %0t: rs1_data_o expected %h, actual %h",
                                 $time, $sampled(rs1_exp), $sampled(rs1_data));
                end

        a_rs2_matches: assert property (@(posedge clk_i) disable iff (reset_i)
                rs2_data == rs2_exp)
                else begin
                        error_count++;
                        $display("** Error at %0t: rs2_data_o expected %h, actual %h",
                                 $time, $sampled(rs2_exp), $sampled(rs2_data));
                end

        a_rs3_matches: assert property (@(posedge clk_i) disable iff (reset_i)
                rs3_data == rs3_exp)
                else begin
                        error_count++;
                        $display("** Error at %0t: rs3_data_o expected %h, actual %h",
                                 $time, $sampled(rs3_exp), $sampled(rs3_data));
                end

        always @(posedge clk_i) begin
                cycle_count++;
                if (cycle_count >= cycle_limit) begin
                        error_count++;
                        $display("timeout: run did not finish within %0d cycles", cycle_limit);
                        $display("errors: %0d", error_count);
                        $display("Something failed");
                        $finish;
                end
        end

        function automatic regfile_pkg::reg_id_t make_id(input logic is_fp, input int idx);
                regfile_pkg::reg_id_t id;
                id.is_fp = is_fp;
                id.idx   = regfile_pkg::reg_idx_t'(idx);
                return id;
        endfunction

        function automatic regfile_pkg::reg_id_t random_id();
                logic [5:0] bits;
                bits = 6'($urandom_range(0, 63));
                return regfile_pkg::reg_id_t'(bits);
        endfunction

        function automatic regfile_pkg::reg_write_t make_write(input regfile_pkg::reg_id_t rd);
                regfile_pkg::reg_write_t w;
                w.rd   = rd;
                w.data = {$urandom(), $urandom()};
                return w;
        endfunction

        task automatic apply_cycle(input regfile_pkg::reg_write_t w,
                                   input regfile_pkg::reg_id_t a,
                                   input regfile_pkg::reg_id_t b,
                                   input regfile_pkg::reg_id_t c);
                @(posedge clk_i);
                #1;
                wr     = w;
                rs1_id = a;
                rs2_id = b;
                rs3_id = c;
        endtask

        // walks all 64 ids, three per cycle, while writing nothing
        task automatic read_all_ids();
                regfile_pkg::reg_write_t idle;
                idle = '0;
                for (int n = 0; n < 64; n += 3) begin
                        apply_cycle(idle, regfile_pkg::reg_id_t'(6'(n)),
                                    regfile_pkg::reg_id_t'(6'(n + 1)),
                                    regfile_pkg::reg_id_t'(6'(n + 2)));
                end
        endtask

        task automatic pulse_reset();
                @(posedge clk_i);
                #1;
                reset_i = 1'b1;
                wr      = make_write(random_id()); // reset must win over this
                repeat (4) @(posedge clk_i);
                #1;
                reset_i = 1'b0;
                wr      = '0;
        endtask

        initial begin
                regfile_pkg::reg_write_t w;
                regfile_pkg::reg_id_t    a;

                void'($urandom(32'hae6b_79b3));
                reset_i = 1'b1;
                wr      = '0;
                rs1_id  = '0;
                rs2_id  = '0;
                rs3_id  = '0;
                repeat (4) @(posedge clk_i);
                #1;
                reset_i = 1'b0;

                read_all_ids();

                // integer writes, previous index read back on rs1
                for (int i = 1; i <= `REG_COUNT; i++) begin
                        w = (i < `REG_COUNT) ? make_write(make_id(1'b0, i)) : '0;
                        apply_cycle(w, make_id(1'b0, i - 1), make_id(1'b0, i % `REG_COUNT),
                                    make_id(1'b1, i % `REG_COUNT));
                end

                // x0 ignores every write
                for (int i = 0; i < 8; i++) begin
                        apply_cycle(make_write(make_id(1'b0, 0)), make_id(1'b0, 0),
                                    make_id(1'b0, $urandom_range(1, 31)), make_id(1'b0, 0));
                end

                // fp writes, integer twin of the previous write on rs2 must not move
                for (int i = 0; i <= `REG_COUNT; i++) begin
                        w = (i < `REG_COUNT) ? make_write(make_id(1'b1, i)) : '0;
                        apply_cycle(w, make_id(1'b1, (i + 31) % `REG_COUNT),
                                    make_id(1'b0, (i + 31) % `REG_COUNT),
                                    make_id(1'b1, i % `REG_COUNT));
                end

                for (int i = 0; i < 300; i++) begin
                        w = make_write(random_id());
                        a = ($urandom_range(0, 3) == 0) ? w.rd : random_id(); // old value case
                        apply_cycle(w, a, random_id(), random_id());
                end

                pulse_reset();
                read_all_ids();

                repeat (2) @(posedge clk_i);
                $display("errors: %0d, cycles: %0d", error_count, cycle_count);
                if (error_count == 0) begin
                        $display("Everything OK");
                end else begin
                        $display("Something failed");
                end
                $finish;
        end

endmodule

// File: hdl/reg_file.sv
`timescale 1ns/100ps

module reg_file (
        input  logic                    clk_i,
        input  logic                    reset_i,
        input  regfile_pkg::reg_write_t wr_i,
        input  regfile_pkg::reg_id_t    rs1_i,
        input  regfile_pkg::reg_id_t    rs2_i,
        input  regfile_pkg::reg_id_t    rs3_i,
        output regfile_pkg::flen_word_t rs1_data_o,
        output regfile_pkg::flen_word_t rs2_data_o,
        output regfile_pkg::flen_word_t rs3_data_o
);

        regfile_pkg::int_bank_t int_regs;
        regfile_pkg::fp_bank_t  fp_regs;

        // writeback goes to both banks, each keeps only its own ids
        int_reg_bank int_bank (
                .clk_i      (clk_i),
                .reset_i    (reset_i),
                .wr_i       (wr_i),
                .int_regs_o (int_regs)
        );

        fp_reg_bank fp_bank (
                .clk_i     (clk_i),
                .reset_i   (reset_i),
                .wr_i      (wr_i),
                .fp_regs_o (fp_regs)
        );

        // three independent combinational read ports, no bypass
        operand_read rs1_read (
                .rs_i       (rs1_i),
                .int_regs_i (int_regs),
                .fp_regs_i  (fp_regs),
                .rs_data_o  (rs1_data_o)
        );

        operand_read rs2_read (
                .rs_i       (rs2_i),
                .int_regs_i (int_regs),
                .fp_regs_i  (fp_regs),
                .rs_data_o  (rs2_data_o)
        );

        // rs3 feeds the fused multiply-add operand
        operand_read rs3_read (
                .rs_i       (rs3_i),
                .int_regs_i (int_regs),
                .fp_regs_i  (fp_regs),
                .rs_data_o  (rs3_data_o)
        );

endmodule

// File: hdl/operand_read.sv
`timescale 1ns/100ps
`include "regfile_macros.svh"

module operand_read (
        input  regfile_pkg::reg_id_t    rs_i,
        input  regfile_pkg::int_bank_t  int_regs_i,
        input  regfile_pkg::fp_bank_t   fp_regs_i,
        output regfile_pkg::flen_word_t rs_data_o
);

        regfile_pkg::xlen_word_t  int_word;
        regfile_pkg::flen_word_t  fp_word;

        // both banks are looked up in parallel, bit 5 picks afterwards
        always_comb begin
                int_word = int_regs_i[rs_i.idx]; // x0 entry is already zero
                fp_word  = fp_regs_i[rs_i.idx];
        end

        always_comb begin
                if (rs_i.is_fp) begin
                        rs_data_o = fp_word;
                end else begin
                        rs_data_o = {`NAN_BOX_FILL, int_word}; // x0 gives ones over zero
                end
        end

        // an integer operand must never leak fp bits into the upper half
        always_comb begin
                if (!rs_i.is_fp) begin
                        a_int_nan_boxed: assert #0 (rs_data_o[`FLEN-1:`XLEN] == `NAN_BOX_FILL)
                                else $error("operand read: integer x%0d not NaN-boxed",
                                            rs_i.idx);
                end
        end

endmodule

// File: hdl/fp_reg_bank.sv
`timescale 1ns/100ps
`include "regfile_macros.svh"

module fp_reg_bank (
        input  logic                    clk_i,
        input  logic                    reset_i,
        input  regfile_pkg::reg_write_t wr_i,
        output regfile_pkg::fp_bank_t   fp_regs_o
);

        // f0..f31, f0 is a normal register
        regfile_pkg::flen_word_t regs_q [`REG_COUNT];

        logic [`REG_COUNT-1:0] wr_sel;

        // only fp ids are decoded here
        always_comb begin
                for (int i = 0; i < `REG_COUNT; i++) begin
                        wr_sel[i] = wr_i.rd.is_fp &&
                                    (wr_i.rd.idx == regfile_pkg::reg_idx_t'(i));
                end
        end

        always_ff @(posedge clk_i) begin
                if (reset_i) begin
                        for (int i = 0; i < `REG_COUNT; i++) begin
                                regs_q[i] <= '0;
                        end
                end else begin
                        for (int i = 0; i < `REG_COUNT; i++) begin
                                if (wr_sel[i]) begin
                                        regs_q[i] <= wr_i.data; // full 64 bits
                                end
                        end
                end
        end

        always_comb begin
                for (int i = 0; i < `REG_COUNT; i++) begin
                        fp_regs_o[i] = regs_q[i];
                end
        end

        // integer writebacks share wr_i but must never disturb this bank
        for (genvar g = 0; g < `REG_COUNT; g++) begin : g_int_hold
                a_int_write_holds_fp: assert property (
                        @(posedge clk_i) disable iff (reset_i)
                        !wr_i.rd.is_fp |=> $stable(regs_q[g]))
                        else $error("fp bank: f%0d changed on an integer write", g);
        end

endmodule

// File: hdl/int_reg_bank.sv
`timescale 1ns/100ps
`include "regfile_macros.svh"

module int_reg_bank (
        input  logic                    clk_i,
        input  logic                    reset_i,
        input  regfile_pkg::reg_write_t wr_i,
        output regfile_pkg::int_bank_t  int_regs_o
);

        // x1..x31, x0 has no flop behind it
        regfile_pkg::xlen_word_t regs_q [1:`REG_COUNT-1];

        // one-hot write select, bit 0 stays low
        logic [`REG_COUNT-1:1] wr_sel;

        always_comb begin
                for (int i = 1; i < `REG_COUNT; i++) begin
                        wr_sel[i] = !wr_i.rd.is_fp &&
                                    (wr_i.rd.idx == regfile_pkg::reg_idx_t'(i));
                end
        end

        always_ff @(posedge clk_i) begin
                if (reset_i) begin
                        for (int i = 1; i < `REG_COUNT; i++) begin
                                regs_q[i] <= '0;
                        end
                end else begin
                        for (int i = 1; i < `REG_COUNT; i++) begin
                                if (wr_sel[i]) begin
                                        regs_q[i] <= wr_i.data[`XLEN-1:0]; // low half only
                                end
                        end
                end
        end

        always_comb begin
                int_regs_o[0] = '0; // hardwired zero
                for (int i = 1; i < `REG_COUNT; i++) begin
                        int_regs_o[i] = regs_q[i];
                end
        end

        // a writeback to x1..x31 is what the read ports see one cycle later
        property p_int_write_lands;
                @(posedge clk_i) disable iff (reset_i)
                (!wr_i.rd.is_fp && (wr_i.rd.idx != '0))
                |=> (int_regs_o[$past(wr_i.rd.idx)] == $past(wr_i.data[`XLEN-1:0]));
        endproperty

        a_int_write_lands: assert property (p_int_write_lands)
                else $error("int bank: write to x%0d did not land", $past(wr_i.rd.idx));

endmodule

// File: hdl/regfile_pkg.sv
`include "regfile_macros.svh"

package regfile_pkg;

        // index inside one bank
        typedef logic [`REG_IDX_W-1:0] reg_idx_t;

        // value of an integer register
        typedef logic [`XLEN-1:0] xlen_word_t;

        // fp register value and read port result
        typedef logic [`FLEN-1:0] flen_word_t;

        // 6-bit register id as the decoder emits it
        typedef struct packed {
                logic     is_fp; // bit 5, picks the fp bank
                reg_idx_t idx;   // bits 4:0
        } reg_id_t;

        // writeback request, present every cycle
        typedef struct packed {
                reg_id_t    rd;   // integer x0 here means no write
                flen_word_t data; // integer writes keep only the low half
        } reg_write_t;

        // bank contents as the read ports see them
        typedef xlen_word_t int_bank_t [`REG_COUNT]; // entry 0 is x0, always zero
        typedef flen_word_t fp_bank_t [`REG_COUNT];

endpackage

// File: hdl/regfile_macros.svh
`ifndef REGFILE_MACROS_SVH
`define REGFILE_MACROS_SVH

// registers per bank, integer and floating point alike
`define REG_COUNT 32

// index width inside one bank
`define REG_IDX_W 5

// integer register width (RV32)
`define XLEN 32

// D extension width, also the width of every read port
`define FLEN 64

// upper half of an integer read, so integer values look like NaN-boxed singles
`define NAN_BOX_FILL {(`XLEN){1'b1}}

`endif
